//--- Makefile
# Verilator build and run of the packed-SIMD ALU testbench
TOP := pext_alu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o Vtb
	@out="$$(./obj_dir/Vtb)"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

//--- dv/pext_alu_tb.sv
/*
 * Testbench for the packed-SIMD ALU. Issues directed and random operations,
 * predicts each result with a reference model and checks the registered
 * output, its valid strobe and the overflow flag one cycle after issue.
 */
`include "pext_consts.svh"

module pext_alu_tb;

  typedef struct packed {
    pext_op_pkg::pext_op_e  op;
    logic [`PEXT_XLEN:0]    expected;
  } issued_t;

  logic                         clk_i;
  logic                         rst_n_i;
  logic                         valid_i;
  pext_op_pkg::pext_op_e        op_i;
  logic [`PEXT_XLEN-1:0]        operand_a_i;
  logic [`PEXT_XLEN-1:0]        operand_b_i;
  logic [`PEXT_XLEN-1:0]        result_o;
  logic                         valid_o;
  logic                         ov_o;

  issued_t exp_q[$];

  pext_alu_top u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (result_o),
    .valid_o     (valid_o),
    .ov_o        (ov_o)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic int saturate(input int v, input int lo, input int hi);
    return (v > hi) ? hi : ((v < lo) ? lo : v);
  endfunction

  // Bits from top downwards that equal ref_bit, stopping at the first miss
  function automatic int lead_run(input int val, input int top, input int ref_bit);
    int  n;
    logic run;
    n   = 0;
    run = 1'b1;
    for (int j = top; j >= 0; j--) begin
      if (run && (((val >> j) & 1) == ref_bit)) n++;
      else run = 1'b0;
    end
    return n;
  endfunction

  // Returns {overflow, result}
  function automatic logic [`PEXT_XLEN:0] expected_result(input pext_op_pkg::pext_op_e op,
      input logic [`PEXT_XLEN-1:0] a, input logic [`PEXT_XLEN-1:0] b);
    int w, lane_mask, ua, ub, sa, sb, r, smin, smax, umax, sh;
    logic [`PEXT_XLEN-1:0] res;
    logic ov;
    w = (op inside {pext_op_pkg::ADD16, pext_op_pkg::SUB16, pext_op_pkg::RADD16,
        pext_op_pkg::URSUB16, pext_op_pkg::KADD16, pext_op_pkg::KSUB16,
        pext_op_pkg::UKSUB16, pext_op_pkg::CMPEQ16, pext_op_pkg::SCMPLT16,
        pext_op_pkg::SMIN16, pext_op_pkg::SRA16, pext_op_pkg::SLL16,
        pext_op_pkg::CLZ16, pext_op_pkg::CLRS16}) ? 16 : 8;
    lane_mask = (1 << w) - 1;
    sh   = (w == 8) ? int'(b[2:0]) : int'(b[3:0]);
    smin = (w == 8) ? int'($signed(`PEXT_SAT_S8_MIN)) : int'($signed(`PEXT_SAT_S16_MIN));
    smax = (w == 8) ? int'(`PEXT_SAT_S8_MAX) : int'(`PEXT_SAT_S16_MAX);
    umax = (w == 8) ? int'(`PEXT_SAT_U8_MAX) : int'(`PEXT_SAT_U16_MAX);
    res  = '0;
    ov   = 1'b0;
    for (int i = 0; i < `PEXT_XLEN / w; i++) begin
      ua = int'(a >> (i * w)) & lane_mask;
      ub = int'(b >> (i * w)) & lane_mask;
      sa = (ua > (lane_mask >> 1)) ? ua - (1 << w) : ua;
      sb = (ub > (lane_mask >> 1)) ? ub - (1 << w) : ub;
      case (op)
        pext_op_pkg::ADD8, pext_op_pkg::ADD16: r = ua + ub;
        pext_op_pkg::SUB8, pext_op_pkg::SUB16: r = ua - ub;
        pext_op_pkg::RADD8, pext_op_pkg::RADD16: r = (sa + sb) >>> 1;
        pext_op_pkg::URADD8: r = (ua + ub) >>> 1;
        pext_op_pkg::RSUB8: r = (sa - sb) >>> 1;
        pext_op_pkg::URSUB16: r = (ua - ub) >>> 1;
        pext_op_pkg::KADD8, pext_op_pkg::KADD16: begin
          r  = saturate(sa + sb, smin, smax);
          ov = ov | (r != sa + sb);
        end
        pext_op_pkg::KSUB16: begin
          r  = saturate(sa - sb, smin, smax);
          ov = ov | (r != sa - sb);
        end
        pext_op_pkg::UKADD8: begin
          r  = saturate(ua + ub, 0, umax);
          ov = ov | (r != ua + ub);
        end
        pext_op_pkg::UKSUB16: begin
          r  = saturate(ua - ub, 0, umax);
          ov = ov | (r != ua - ub);
        end
        pext_op_pkg::CMPEQ8, pext_op_pkg::CMPEQ16: r = (ua == ub) ? lane_mask : 0;
        pext_op_pkg::SCMPLT8, pext_op_pkg::SCMPLT16: r = (sa < sb) ? lane_mask : 0;
        pext_op_pkg::UCMPLE8: r = (ua <= ub) ? lane_mask : 0;
        pext_op_pkg::SMIN16: r = (sa < sb) ? ua : ub;
        pext_op_pkg::UMAX8: r = (ua >= ub) ? ua : ub;
        pext_op_pkg::SRA16: r = sa >>> sh;
        pext_op_pkg::SRL8: r = ua >> sh;
        pext_op_pkg::SLL16: r = ua << sh;
        pext_op_pkg::CLZ8, pext_op_pkg::CLZ16: r = lead_run(ua, w - 1, 0);
        pext_op_pkg::CLRS16: r = lead_run(ua, w - 2, (ua >> (w - 1)) & 1);
        default: r = 0;
      endcase
      res = res | (`PEXT_XLEN'(r & lane_mask) << (i * w));
    end
    return {ov, res};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [`PEXT_XLEN-1:0] got,
      input logic [`PEXT_XLEN-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL t=%0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Output is stable at the falling edge; valid_o must follow valid_i by one cycle
  initial begin : compare_proc
    logic                  exp_valid;
    logic                  have_result;
    logic [`PEXT_XLEN-1:0] last_result;
    issued_t               item;
    pext_op_pkg::pext_op_e op_seen;
    exp_valid   = 1'b0;
    have_result = 1'b0;
    last_result = '0;
    @(posedge clk_i);
    forever begin
      @(negedge clk_i);
      check_value("valid_o", `PEXT_XLEN'(valid_o), `PEXT_XLEN'(exp_valid));
      if (valid_o) begin
        if (exp_q.size() == 0) abort_run("valid_o went high with no operation outstanding");
        item    = exp_q.pop_front();
        op_seen = item.op;
        check_value({op_seen.name(), " result"}, result_o, item.expected[`PEXT_XLEN-1:0]);
        check_value({op_seen.name(), " ov_o"}, `PEXT_XLEN'(ov_o),
                    `PEXT_XLEN'(item.expected[`PEXT_XLEN]));
        last_result = result_o;
        have_result = 1'b1;
      end else begin
        check_value("ov_o while idle", `PEXT_XLEN'(ov_o), '0);
        if (have_result) check_value("held result_o", result_o, last_result);
      end
      exp_valid = valid_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  task automatic issue_op(input pext_op_pkg::pext_op_e op, input logic [`PEXT_XLEN-1:0] a,
      input logic [`PEXT_XLEN-1:0] b);
    issued_t item;
    @(posedge clk_i);
    valid_i     <= 1'b1;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    item.op       = op;
    item.expected = expected_result(op, a, b);
    exp_q.push_back(item);
  endtask

  // Operands keep moving so a held result is visible
  task automatic idle_cycle;
    @(posedge clk_i);
    valid_i     <= 1'b0;
    operand_a_i <= $urandom;
    operand_b_i <= $urandom;
  endtask

  task automatic wait_drain;
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 20) begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_q.size() != 0) abort_run("timed out waiting for valid_o on the last operations");
  endtask

  initial begin : stimulus
    pext_op_pkg::pext_op_e op;
    logic [`PEXT_XLEN-1:0] a;
    logic [`PEXT_XLEN-1:0] b;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = pext_op_pkg::ADD8;
    operand_a_i = '0;
    operand_b_i = '0;
    void'($urandom(22));
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Clamp edges: 0x7F+1, 0x80-1, 0xFFFF+1
    issue_op(pext_op_pkg::KADD8,   32'h0000_807F, 32'h0000_FF01);
    issue_op(pext_op_pkg::KSUB16,  32'h8000_7FFF, 32'h0001_FFFF);
    issue_op(pext_op_pkg::KADD16,  32'h0000_FFFF, 32'h0000_0001);
    issue_op(pext_op_pkg::UKADD8,  32'hFF00_FF80, 32'h0101_0180);
    issue_op(pext_op_pkg::UKSUB16, 32'h0000_0005, 32'h0001_0003);
    issue_op(pext_op_pkg::ADD8,    32'h7FFF_8001, 32'h0101_80FF);
    issue_op(pext_op_pkg::RSUB8,   32'h8000_7F01, 32'h7F01_80FF);
    idle_cycle();
    issue_op(pext_op_pkg::SRA16,   32'h8001_7FF0, 32'h0000_000F);
    issue_op(pext_op_pkg::SLL16,   32'hFFFF_0001, 32'h0000_0013);
    issue_op(pext_op_pkg::SRL8,    32'h80FF_7F01, 32'h0000_0007);
    // Zero lanes count the full lane width
    issue_op(pext_op_pkg::CLZ8,    32'h0001_800F, 32'h0);
    issue_op(pext_op_pkg::CLZ16,   32'h0000_0001, 32'h0);
    issue_op(pext_op_pkg::CLRS16,  32'hFFFF_0000, 32'h0);
    issue_op(pext_op_pkg::CLRS16,  32'h7FFF_C000, 32'h0);
    idle_cycle();
    idle_cycle();

    // Random operands per op, mostly back to back
    for (int k = 0; k <= int'(pext_op_pkg::CLRS16); k++) begin
      op = pext_op_pkg::pext_op_e'(k);
      repeat (24) begin
        a = $urandom;
        b = ($urandom % 3 == 0) ? (a ^ ($urandom & 32'h0000_FF00)) : $urandom;
        if ($urandom % 6 == 0) idle_cycle();
        issue_op(op, a, b);
      end
    end

    idle_cycle();
    wait_drain();
    repeat (2) @(posedge clk_i);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- rtl/pext_alu_top.sv
/*
 * Top level of the packed-SIMD ALU. One operation per clock in,
 * registered result with valid and overflow one cycle later.
 */
`include "pext_consts.svh"

module pext_alu_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  input  pext_op_pkg::pext_op_e  op_i,
  input  logic [`PEXT_XLEN-1:0]  operand_a_i,
  input  logic [`PEXT_XLEN-1:0]  operand_b_i,
  output logic [`PEXT_XLEN-1:0]  result_o,
  output logic                   valid_o,
  output logic                   ov_o
);

  pext_lane_pkg::lane_width_e width;
  pext_lane_pkg::add_mode_e   mode;
  pext_op_pkg::pext_class_e   op_class;
  logic                       is_signed, sub, cmp_le, cmp_eq, minmax_max;
  logic                       shift_left, shift_arith, count_sign, add_ov;
  logic [`PEXT_NBYTES-1:0]    diff_sign;
  logic [`PEXT_XLEN-1:0]      sum, mask, minmax, shift, count;

  pext_op_decoder u_decoder (
    .op_i          (op_i),
    .width_o       (width),
    .signed_o      (is_signed),
    .sub_o         (sub),
    .mode_o        (mode),
    .cmp_le_o      (cmp_le),
    .cmp_eq_o      (cmp_eq),
    .minmax_max_o  (minmax_max),
    .shift_left_o  (shift_left),
    .shift_arith_o (shift_arith),
    .count_sign_o  (count_sign),
    .class_o       (op_class)
  );

  pext_simd_adder u_adder (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .width_i     (width),
    .signed_i    (is_signed),
    .sub_i       (sub),
    .mode_i      (mode),
    .sum_o       (sum),
    .diff_sign_o (diff_sign),
    .ov_o        (add_ov)
  );

  pext_lane_compare u_compare (
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .sum_i        (sum),
    .diff_sign_i  (diff_sign),
    .width_i      (width),
    .cmp_le_i     (cmp_le),
    .cmp_eq_i     (cmp_eq),
    .minmax_max_i (minmax_max),
    .mask_o       (mask),
    .minmax_o     (minmax)
  );

  pext_lane_shifter u_shifter (
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .width_i       (width),
    .shift_left_i  (shift_left),
    .shift_arith_i (shift_arith),
    .shift_o       (shift)
  );

  pext_lead_count u_lead_count (
    .operand_a_i  (operand_a_i),
    .width_i      (width),
    .count_sign_i (count_sign),
    .count_o      (count)
  );

  pext_result_stage u_result_stage (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .class_i  (op_class),
    .sum_i    (sum),
    .mask_i   (mask),
    .minmax_i (minmax),
    .shift_i  (shift),
    .count_i  (count),
    .ov_i     (add_ov),
    .result_o (result_o),
    .valid_o  (valid_o),
    .ov_o     (ov_o)
  );

endmodule

//--- rtl/pext_consts.svh
/*
 * Word geometry and clamp limits of the packed-SIMD ALU.
 * Included by the RTL and by the testbench reference model.
 */
`ifndef PEXT_CONSTS_SVH
`define PEXT_CONSTS_SVH

// Word and lane geometry
`define PEXT_XLEN   32
`define PEXT_NBYTES 4

// Clamp limits for saturating add/sub
`define PEXT_SAT_S8_MIN  8'h80
`define PEXT_SAT_S8_MAX  8'h7F
`define PEXT_SAT_U8_MAX  8'hFF
`define PEXT_SAT_S16_MIN 16'h8000
`define PEXT_SAT_S16_MAX 16'h7FFF
`define PEXT_SAT_U16_MAX 16'hFFFF

`endif

//--- rtl/pext_lane_compare.sv
/*
 * Lane compares and min/max, driven by the adder's a-minus-b.
 */
`include "pext_consts.svh"

module pext_lane_compare (
  input  logic [`PEXT_XLEN-1:0]       operand_a_i,
  input  logic [`PEXT_XLEN-1:0]       operand_b_i,
  input  logic [`PEXT_XLEN-1:0]       sum_i,
  input  logic [`PEXT_NBYTES-1:0]     diff_sign_i,
  input  pext_lane_pkg::lane_width_e  width_i,
  input  logic                        cmp_le_i,
  input  logic                        cmp_eq_i,
  input  logic                        minmax_max_i,
  output logic [`PEXT_XLEN-1:0]       mask_o,
  output logic [`PEXT_XLEN-1:0]       minmax_o
);

  logic [`PEXT_NBYTES-1:0] byte_zero, lane_eq, lane_lt, lane_hit, take_a;

  for (genvar k = 0; k < `PEXT_NBYTES; k++) begin : gen_zero
    assign byte_zero[k] = (sum_i[8*k +: 8] == 8'h00);
  end

  // Widen byte results to the lane they belong to
  assign lane_eq = (width_i == pext_lane_pkg::LW8) ? byte_zero
                 : {{2{&byte_zero[3:2]}}, {2{&byte_zero[1:0]}}};
  assign lane_lt = (width_i == pext_lane_pkg::LW8) ? diff_sign_i
                 : {{2{diff_sign_i[3]}}, {2{diff_sign_i[1]}}};

  assign lane_hit = cmp_eq_i ? lane_eq
                             : (lane_lt | (lane_eq & {`PEXT_NBYTES{cmp_le_i}}));

  // Min keeps a when a < b, max keeps a otherwise
  assign take_a = minmax_max_i ? ~lane_lt : lane_lt;

  for (genvar k = 0; k < `PEXT_NBYTES; k++) begin : gen_lane_out
    assign mask_o[8*k +: 8]   = {8{lane_hit[k]}};
    assign minmax_o[8*k +: 8] = take_a[k] ? operand_a_i[8*k +: 8] : operand_b_i[8*k +: 8];
  end

endmodule

//--- rtl/pext_lane_pkg.sv
/*
 * Lane width and adder output mode shared by the decoder and the units.
 */
package pext_lane_pkg;

  typedef enum logic {
    LW8  = 1'b0,
    LW16 = 1'b1
  } lane_width_e;

  // Wrap, halve by truncation, or clamp to the lane limits
  typedef enum logic [1:0] {
    ADD_WRAP  = 2'd0,
    ADD_HALVE = 2'd1,
    ADD_SAT   = 2'd2
  } add_mode_e;

endpackage

//--- rtl/pext_lane_shifter.sv
/*
 * Per-lane shifts on one 32-bit right shifter. Left shifts run on the
 * bit-reversed word; lane masks keep bits inside their lane.
 */
`include "pext_consts.svh"

module pext_lane_shifter (
  input  logic [`PEXT_XLEN-1:0]       operand_a_i,
  input  logic [`PEXT_XLEN-1:0]       operand_b_i,
  input  pext_lane_pkg::lane_width_e  width_i,
  input  logic                        shift_left_i,
  input  logic                        shift_arith_i,
  output logic [`PEXT_XLEN-1:0]       shift_o
);

  logic [3:0]              shamt;
  logic [7:0]              mask8;
  logic [15:0]             mask16;
  logic [`PEXT_NBYTES-1:0] lane_sign;
  logic [`PEXT_XLEN-1:0]   a_rev, shift_in, shifted, lane_mask, sign_fill;
  logic [`PEXT_XLEN-1:0]   lane_res, lane_res_rev;

  // 8-bit lanes take three amount bits, 16-bit lanes take four
  assign shamt = (width_i == pext_lane_pkg::LW8) ? {1'b0, operand_b_i[2:0]}
                                                 : operand_b_i[3:0];

  for (genvar i = 0; i < `PEXT_XLEN; i++) begin : gen_rev
    assign a_rev[i]        = operand_a_i[`PEXT_XLEN-1-i];
    assign lane_res_rev[i] = lane_res[`PEXT_XLEN-1-i];
  end

  assign shift_in = shift_left_i ? a_rev : operand_a_i;
  assign shifted  = shift_in >> shamt;

  // Zeros in the top shamt bits of every lane
  assign mask8     = 8'hFF >> shamt[2:0];
  assign mask16    = 16'hFFFF >> shamt;
  assign lane_mask = (width_i == pext_lane_pkg::LW8) ? {`PEXT_NBYTES{mask8}} : {2{mask16}};

  assign lane_sign = {`PEXT_NBYTES{shift_arith_i}}
                   & ((width_i == pext_lane_pkg::LW8)
                      ? {operand_a_i[31], operand_a_i[23], operand_a_i[15], operand_a_i[7]}
                      : {{2{operand_a_i[31]}}, {2{operand_a_i[15]}}});

  for (genvar k = 0; k < `PEXT_NBYTES; k++) begin : gen_fill
    assign sign_fill[8*k +: 8] = {8{lane_sign[k]}} & ~lane_mask[8*k +: 8];
  end

  assign lane_res = (shifted & lane_mask) | sign_fill;
  assign shift_o  = shift_left_i ? lane_res_rev : lane_res;

endmodule

//--- rtl/pext_lead_count.sv
/*
 * Leading-zero and leading-sign counts per lane, summed by a popcount
 * tree over a run vector that stays set while bits match the lane top.
 */
`include "pext_consts.svh"

module pext_lead_count (
  input  logic [`PEXT_XLEN-1:0]       operand_a_i,
  input  pext_lane_pkg::lane_width_e  width_i,
  input  logic                        count_sign_i,
  output logic [`PEXT_XLEN-1:0]       count_o
);

  logic [`PEXT_XLEN-1:0] run;
  logic [1:0] cnt2 [16];
  logic [2:0] cnt3 [8];
  logic [3:0] cnt4 [4];
  logic [4:0] cnt5 [2];

  // Sign count leaves the sign bit itself out of the run
  always_comb begin
    logic chain;
    logic ref_bit;
    logic lane_msb;
    chain   = 1'b0;
    ref_bit = 1'b0;
    for (int i = `PEXT_XLEN - 1; i >= 0; i--) begin
      lane_msb = (width_i == pext_lane_pkg::LW8) ? (i % 8 == 7) : (i % 16 == 15);
      if (lane_msb) begin
        ref_bit = count_sign_i & operand_a_i[i];
        run[i]  = ~count_sign_i & ~operand_a_i[i];
        chain   = count_sign_i | ~operand_a_i[i];
      end else begin
        run[i] = chain & (operand_a_i[i] == ref_bit);
        chain  = run[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Popcount tree
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < 16; i++) begin : gen_pair
    assign cnt2[i] = {1'b0, run[2*i]} + {1'b0, run[2*i+1]};
  end
  for (genvar i = 0; i < 8; i++) begin : gen_nibble
    assign cnt3[i] = {1'b0, cnt2[2*i]} + {1'b0, cnt2[2*i+1]};
  end
  for (genvar i = 0; i < 4; i++) begin : gen_byte
    assign cnt4[i] = {1'b0, cnt3[2*i]} + {1'b0, cnt3[2*i+1]};
  end
  for (genvar i = 0; i < 2; i++) begin : gen_half
    assign cnt5[i] = {1'b0, cnt4[2*i]} + {1'b0, cnt4[2*i+1]};
  end

  assign count_o = (width_i == pext_lane_pkg::LW8)
      ? {4'h0, cnt4[3], 4'h0, cnt4[2], 4'h0, cnt4[1], 4'h0, cnt4[0]}
      : {11'h000, cnt5[1], 11'h000, cnt5[0]};

endmodule

//--- rtl/pext_op_decoder.sv
/*
 * Operation decoder. Turns the operation code into the lane width,
 * signedness, adder controls, unit controls and the result class.
 */
module pext_op_decoder (
  input  pext_op_pkg::pext_op_e       op_i,
  output pext_lane_pkg::lane_width_e  width_o,
  output logic                        signed_o,
  output logic                        sub_o,
  output pext_lane_pkg::add_mode_e    mode_o,
  output logic                        cmp_le_o,
  output logic                        cmp_eq_o,
  output logic                        minmax_max_o,
  output logic                        shift_left_o,
  output logic                        shift_arith_o,
  output logic                        count_sign_o,
  output pext_op_pkg::pext_class_e    class_o
);

  // Lane width and signedness
  always_comb begin
    unique case (op_i)
      pext_op_pkg::ADD16,   pext_op_pkg::SUB16,    pext_op_pkg::RADD16,
      pext_op_pkg::URSUB16, pext_op_pkg::KADD16,   pext_op_pkg::KSUB16,
      pext_op_pkg::UKSUB16, pext_op_pkg::CMPEQ16,  pext_op_pkg::SCMPLT16,
      pext_op_pkg::SMIN16,  pext_op_pkg::SRA16,    pext_op_pkg::SLL16,
      pext_op_pkg::CLZ16,   pext_op_pkg::CLRS16: width_o = pext_lane_pkg::LW16;
      default: width_o = pext_lane_pkg::LW8;
    endcase

    unique case (op_i)
      pext_op_pkg::RADD8,   pext_op_pkg::RADD16,   pext_op_pkg::RSUB8,
      pext_op_pkg::KADD8,   pext_op_pkg::KADD16,   pext_op_pkg::KSUB16,
      pext_op_pkg::SCMPLT8, pext_op_pkg::SCMPLT16, pext_op_pkg::SMIN16: signed_o = 1'b1;
      default: signed_o = 1'b0;
    endcase
  end

  // Adder controls and unit selects
  always_comb begin
    sub_o         = 1'b0;
    mode_o        = pext_lane_pkg::ADD_WRAP;
    cmp_le_o      = 1'b0;
    cmp_eq_o      = 1'b0;
    minmax_max_o  = 1'b0;
    shift_left_o  = 1'b0;
    shift_arith_o = 1'b0;
    count_sign_o  = 1'b0;
    class_o       = pext_op_pkg::CLS_ADD;

    unique case (op_i)
      pext_op_pkg::SUB8, pext_op_pkg::SUB16: sub_o = 1'b1;
      pext_op_pkg::RADD8, pext_op_pkg::RADD16,
      pext_op_pkg::URADD8: mode_o = pext_lane_pkg::ADD_HALVE;
      pext_op_pkg::RSUB8, pext_op_pkg::URSUB16: begin
        sub_o  = 1'b1;
        mode_o = pext_lane_pkg::ADD_HALVE;
      end
      pext_op_pkg::KADD8, pext_op_pkg::KADD16,
      pext_op_pkg::UKADD8: mode_o = pext_lane_pkg::ADD_SAT;
      pext_op_pkg::KSUB16, pext_op_pkg::UKSUB16: begin
        sub_o  = 1'b1;
        mode_o = pext_lane_pkg::ADD_SAT;
      end
      // Compares and min/max run the adder as a wrapping subtract
      pext_op_pkg::CMPEQ8, pext_op_pkg::CMPEQ16,
      pext_op_pkg::SCMPLT8, pext_op_pkg::SCMPLT16,
      pext_op_pkg::UCMPLE8: begin
        sub_o    = 1'b1;
        cmp_eq_o = (op_i == pext_op_pkg::CMPEQ8) || (op_i == pext_op_pkg::CMPEQ16);
        cmp_le_o = (op_i == pext_op_pkg::UCMPLE8);
        class_o  = pext_op_pkg::CLS_CMP;
      end
      pext_op_pkg::SMIN16, pext_op_pkg::UMAX8: begin
        sub_o        = 1'b1;
        minmax_max_o = (op_i == pext_op_pkg::UMAX8);
        class_o      = pext_op_pkg::CLS_MINMAX;
      end
      pext_op_pkg::SRA16, pext_op_pkg::SRL8, pext_op_pkg::SLL16: begin
        shift_arith_o = (op_i == pext_op_pkg::SRA16);
        shift_left_o  = (op_i == pext_op_pkg::SLL16);
        class_o       = pext_op_pkg::CLS_SHIFT;
      end
      pext_op_pkg::CLZ8, pext_op_pkg::CLZ16, pext_op_pkg::CLRS16: begin
        count_sign_o = (op_i == pext_op_pkg::CLRS16);
        class_o      = pext_op_pkg::CLS_COUNT;
      end
      default: ;
    endcase
  end

  // Class stays legal for every known operation code
  always_comb begin
    if (!$isunknown(op_i)) begin
      a_class_known: assert (class_o inside {pext_op_pkg::CLS_ADD, pext_op_pkg::CLS_CMP,
          pext_op_pkg::CLS_MINMAX, pext_op_pkg::CLS_SHIFT, pext_op_pkg::CLS_COUNT})
        else $error("undefined class for op %0d", op_i);
    end
  end

endmodule

//--- rtl/pext_op_pkg.sv
/*
 * Operation codes accepted by the ALU and the result classes
 * that pick which unit drives the registered output.
 */
package pext_op_pkg;

  // Operation code, grouped by the unit that serves it
  typedef enum logic [4:0] {
    // Wrapping add/sub
    ADD8 = 5'd0, ADD16, SUB8, SUB16,
    // Halving add/sub
    RADD8, RADD16, URADD8, RSUB8, URSUB16,
    // Saturating add/sub
    KADD8, KADD16, UKADD8, KSUB16, UKSUB16,
    // Lane compares, returned as masks
    CMPEQ8, CMPEQ16, SCMPLT8, SCMPLT16, UCMPLE8,
    SMIN16, UMAX8,
    SRA16, SRL8, SLL16,
    CLZ8, CLZ16, CLRS16
  } pext_op_e;

  // Unit whose result is registered
  typedef enum logic [2:0] {
    CLS_ADD    = 3'd0,
    CLS_CMP    = 3'd1,
    CLS_MINMAX = 3'd2,
    CLS_SHIFT  = 3'd3,
    CLS_COUNT  = 3'd4
  } pext_class_e;

endpackage

//--- rtl/pext_result_stage.sv
/*
 * Output register of the ALU. Picks the unit result by class and
 * registers result, valid and overflow one cycle after issue.
 */
`include "pext_consts.svh"

module pext_result_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  pext_op_pkg::pext_class_e  class_i,
  input  logic [`PEXT_XLEN-1:0]     sum_i,
  input  logic [`PEXT_XLEN-1:0]     mask_i,
  input  logic [`PEXT_XLEN-1:0]     minmax_i,
  input  logic [`PEXT_XLEN-1:0]     shift_i,
  input  logic [`PEXT_XLEN-1:0]     count_i,
  input  logic                      ov_i,
  output logic [`PEXT_XLEN-1:0]     result_o,
  output logic                      valid_o,
  output logic                      ov_o
);

  logic [`PEXT_XLEN-1:0] unit_result;

  always_comb begin
    unique case (class_i)
      pext_op_pkg::CLS_CMP:    unit_result = mask_i;
      pext_op_pkg::CLS_MINMAX: unit_result = minmax_i;
      pext_op_pkg::CLS_SHIFT:  unit_result = shift_i;
      pext_op_pkg::CLS_COUNT:  unit_result = count_i;
      default:                 unit_result = sum_i;
    endcase
  end

  // Result holds over idle cycles
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= unit_result;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      ov_o    <= 1'b0;
    end else begin
      valid_o <= valid_i;
      ov_o    <= valid_i & ov_i;
    end
  end

  a_ov_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ov_o |-> valid_o);

  a_quiet_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> (!valid_o && !ov_o));

endmodule

//--- rtl/pext_simd_adder.sv
/*
 * Lane-split adder built from four byte adders. Carries are broken at
 * lane edges; the output wraps, halves or saturates per mode_i.
 */
`include "pext_consts.svh"

module pext_simd_adder (
  input  logic [`PEXT_XLEN-1:0]       operand_a_i,
  input  logic [`PEXT_XLEN-1:0]       operand_b_i,
  input  pext_lane_pkg::lane_width_e  width_i,
  input  logic                        signed_i,
  input  logic                        sub_i,
  input  pext_lane_pkg::add_mode_e    mode_i,
  output logic [`PEXT_XLEN-1:0]       sum_o,
  output logic [`PEXT_NBYTES-1:0]     diff_sign_o,
  output logic                        ov_o
);

  logic [`PEXT_XLEN-1:0]   b_in;
  logic [8:0]              byte_sum [`PEXT_NBYTES];
  logic [`PEXT_NBYTES-1:0] carry_in, lane_top, ext_msb, lane_sat;
  logic [`PEXT_XLEN-1:0]   wrap_res, halve_res, sat_res;

  assign b_in     = sub_i ? ~operand_b_i : operand_b_i;
  assign lane_top = (width_i == pext_lane_pkg::LW8) ? 4'b1111 : 4'b1010;

  for (genvar k = 0; k < `PEXT_NBYTES; k++) begin : gen_byte
    localparam int Hi = k | 1;
    logic [7:0]  clamp8;
    logic [15:0] clamp16;

    // Subtract injects its +1 at each lane's low byte
    if (k == 0) begin : gen_cin_low
      assign carry_in[k] = sub_i;
    end else begin : gen_cin_chain
      assign carry_in[k] = lane_top[k-1] ? sub_i : byte_sum[k-1][8];
    end

    assign byte_sum[k] = {1'b0, operand_a_i[8*k +: 8]} + {1'b0, b_in[8*k +: 8]}
                       + {8'h00, carry_in[k]};
    assign wrap_res[8*k +: 8] = byte_sum[k][7:0];

    // Bit above the lane in full precision, valid on lane top bytes
    assign ext_msb[k] = (signed_i & operand_a_i[8*k+7])
                      ^ (signed_i ? b_in[8*k+7] : sub_i)
                      ^ byte_sum[k][8];
    assign lane_sat[k] = lane_top[k]
                       & (signed_i ? (ext_msb[k] ^ byte_sum[k][7]) : ext_msb[k]);

    if (k == `PEXT_NBYTES - 1) begin : gen_halve_top
      assign halve_res[8*k +: 8] = {ext_msb[k], wrap_res[8*k+1 +: 7]};
    end else begin : gen_halve
      assign halve_res[8*k +: 8] = {lane_top[k] ? ext_msb[k] : wrap_res[8*k+8],
                                    wrap_res[8*k+1 +: 7]};
    end

    // Unsigned subtract clamps low, everything else by the sign of the excess
    assign clamp8  = signed_i ? (ext_msb[k] ? `PEXT_SAT_S8_MIN : `PEXT_SAT_S8_MAX)
                              : (sub_i ? 8'h00 : `PEXT_SAT_U8_MAX);
    assign clamp16 = signed_i ? (ext_msb[Hi] ? `PEXT_SAT_S16_MIN : `PEXT_SAT_S16_MAX)
                              : (sub_i ? 16'h0000 : `PEXT_SAT_U16_MAX);
    assign sat_res[8*k +: 8] = (width_i == pext_lane_pkg::LW8)
        ? (lane_sat[k]  ? clamp8                 : wrap_res[8*k +: 8])
        : (lane_sat[Hi] ? clamp16[8*(k%2) +: 8]  : wrap_res[8*k +: 8]);
  end

  always_comb begin
    unique case (mode_i)
      pext_lane_pkg::ADD_HALVE: sum_o = halve_res;
      pext_lane_pkg::ADD_SAT:   sum_o = sat_res;
      default:                  sum_o = wrap_res;
    endcase
  end

  assign diff_sign_o = ext_msb;
  assign ov_o        = (mode_i == pext_lane_pkg::ADD_SAT) & (|lane_sat);

endmodule

//--- sim.f
+incdir+rtl
rtl/pext_op_pkg.sv
rtl/pext_lane_pkg.sv
rtl/pext_op_decoder.sv
rtl/pext_simd_adder.sv
rtl/pext_lane_compare.sv
rtl/pext_lane_shifter.sv
rtl/pext_lead_count.sv
rtl/pext_result_stage.sv
rtl/pext_alu_top.sv
dv/pext_alu_tb.sv
